/* source/shop_pkg.sv */
package shop_pkg;

	typedef logic [15:0] money_t;
	typedef logic [5:0]  item_num_t;
	typedef logic [11:0] exp_t;
	typedef logic [7:0]  user_id_t;

	typedef enum logic [1:0] {
		item_none,
		item_small,
		item_medium,
		item_large
	} item_id_e;

	typedef enum logic [1:0] {
		lvl_platinum = 2'd0,
		lvl_gold     = 2'd1,
		lvl_silver   = 2'd2,
		lvl_copper   = 2'd3
	} level_e;

	// codes other than buy and deposit are ignored
	typedef enum logic [3:0] {
		act_none    = 4'd0,
		act_buy     = 4'd1,
		act_deposit = 4'd4
	} action_e;

	typedef enum logic [3:0] {
		no_err         = 4'd0,
		inv_not_enough = 4'd2,
		out_of_money   = 4'd3,
		inv_full       = 4'd4,
		wallet_full    = 4'd8
	} err_e;

	typedef struct packed {
		item_num_t large_num;
		item_num_t medium_num;
		item_num_t small_num;
		level_e    level;
		exp_t      exp;
	} shop_info_t;

	typedef struct packed {
		item_id_e  item_id;
		item_num_t item_num;
		user_id_t  seller_id;
	} shop_hist_t;

	typedef struct packed {
		money_t     money;
		shop_hist_t shop_history;
	} user_info_t;

	// shop half sits in the upper memory word
	typedef struct packed {
		shop_info_t shop;
		user_info_t user;
	} account_t;

	typedef union packed {
		money_t money;
		struct packed {
			logic [7:0] pad;
			user_id_t   val;
		} id;
		struct packed {
			logic [11:0] pad;
			action_e     val;
		} action;
		struct packed {
			logic [13:0] pad;
			item_id_e    val;
		} item;
		struct packed {
			logic [9:0] pad;
			item_num_t  val;
		} count;
	} data_in_t;

	typedef enum logic [3:0] {
		s_idle,
		s_user_req,
		s_user_wait,
		s_input,
		s_seller_req,
		s_seller_wait,
		s_buy_calc,
		s_dep_calc,
		s_seller_wr,
		s_seller_wr_wait,
		s_user_wr,
		s_user_wr_wait,
		s_out
	} state_e;

	localparam money_t price_small  = 16'd100;
	localparam money_t price_medium = 16'd200;
	localparam money_t price_large  = 16'd300;

	localparam money_t fee_platinum = 16'd10;
	localparam money_t fee_gold     = 16'd30;
	localparam money_t fee_silver   = 16'd50;
	localparam money_t fee_copper   = 16'd70;

	localparam exp_t exp_small  = 12'd20;
	localparam exp_t exp_medium = 12'd40;
	localparam exp_t exp_large  = 12'd60;

	localparam exp_t exp_to_silver   = 12'd1000;
	localparam exp_t exp_to_gold     = 12'd2500;
	localparam exp_t exp_to_platinum = 12'd4000;

	localparam money_t money_max = 16'd65535;

	localparam int dram_word_bits = 64;

endpackage

/* source/account_bus_if.sv */
`timescale 1ns/1ps

interface account_bus_if;
	import shop_pkg::*;

	logic     req_valid;
	logic     req_write;
	user_id_t req_addr;
	account_t req_data;
	logic     resp_valid;
	account_t resp_data;

	modport core (
		output req_valid,
		output req_write,
		output req_addr,
		output req_data,
		input  resp_valid,
		input  resp_data
	);

	modport port (
		input  req_valid,
		input  req_write,
		input  req_addr,
		input  req_data,
		output resp_valid,
		output resp_data
	);

endinterface

/* source/dram_port.sv */
`timescale 1ns/1ps

module dram_port (
	input  logic                                 clk,
	input  logic                                 inf,
	account_bus_if.port                          bus,
	input  logic                                 c_out_valid,
	input  logic [shop_pkg::dram_word_bits-1:0]  c_data_r,
	output logic                                 c_in_valid,
	output logic                                 c_r_wb,
	output shop_pkg::user_id_t                   c_addr,
	output logic [shop_pkg::dram_word_bits-1:0]  c_data_w
);

	// memory keeps each 32-bit half in reversed byte order
	function automatic logic [31:0] swap_bytes(input logic [31:0] w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	assign bus.resp_valid = c_out_valid;
	assign bus.resp_data  = {swap_bytes(c_data_r[63:32]), swap_bytes(c_data_r[31:0])};

	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			c_in_valid <= 1'b0;
			c_r_wb     <= 1'b0;
			c_addr     <= '0;
		end else begin
			c_in_valid <= bus.req_valid;
			// high only alongside a read strobe
			c_r_wb     <= bus.req_valid && !bus.req_write;
			c_addr     <= bus.req_addr;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.req_valid) begin
			c_data_w <= {swap_bytes(bus.req_data.shop), swap_bytes(bus.req_data.user)};
		end
	end

endmodule

/* source/shop_fsm.sv */
`timescale 1ns/1ps

module shop_fsm (
	input  logic               clk,
	input  logic               inf,
	input  logic               id_valid,
	input  logic               act_valid,
	input  logic               amnt_valid,
	input  shop_pkg::action_e  action,
	input  logic               calc_ok,
	account_bus_if.core        bus,
	output shop_pkg::state_e   state,
	output shop_pkg::action_e  cur_action
);
	import shop_pkg::*;

	state_e next_state;
	logic   last_seen;
	logic   last_now;

	// seller id or amount may arrive while the user read is still pending
	assign last_now = last_seen || id_valid || amnt_valid;

	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			last_seen <= 1'b0;
		end else if (state == s_idle) begin
			last_seen <= 1'b0;
		end else if (id_valid || amnt_valid) begin
			last_seen <= 1'b1;
		end
	end

	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			cur_action <= act_none;
		end else if (state == s_idle) begin
			cur_action <= act_none;
		end else if (act_valid && (action == act_buy || action == act_deposit)) begin
			cur_action <= action;
		end
	end

	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle:
				if (id_valid)
					next_state = s_user_req;
			s_user_req:
				next_state = s_user_wait;
			s_user_wait:
				if (bus.resp_valid)
					next_state = s_input;
			s_input:
				if (last_now) begin
					if (cur_action == act_buy)
						next_state = s_seller_req;
					else if (cur_action == act_deposit)
						next_state = s_dep_calc;
				end
			s_seller_req:
				next_state = s_seller_wait;
			s_seller_wait:
				if (bus.resp_valid)
					next_state = s_buy_calc;
			s_buy_calc:
				next_state = calc_ok ? s_seller_wr : s_out;
			s_dep_calc:
				next_state = calc_ok ? s_user_wr : s_out;
			s_seller_wr:
				next_state = s_seller_wr_wait;
			s_seller_wr_wait:
				if (bus.resp_valid)
					next_state = s_user_wr;
			s_user_wr:
				next_state = s_user_wr_wait;
			s_user_wr_wait:
				if (bus.resp_valid)
					next_state = s_out;
			s_out:
				next_state = s_idle;
			default:
				next_state = s_idle;
		endcase
	end

	// one request per request state, then hold in the matching wait
	assign bus.req_valid = (state == s_user_req) || (state == s_seller_req) ||
		(state == s_seller_wr) || (state == s_user_wr);
	assign bus.req_write = (state == s_seller_wr) || (state == s_user_wr);

endmodule

/* source/account_store.sv */
`timescale 1ns/1ps

module account_store (
	input  logic                 clk,
	input  logic                 inf,
	input  shop_pkg::state_e     state,
	input  shop_pkg::data_in_t   data_in,
	input  logic                 id_valid,
	input  logic                 item_valid,
	input  logic                 num_valid,
	input  logic                 amnt_valid,
	account_bus_if.core          bus,
	input  shop_pkg::account_t   next_user,
	input  shop_pkg::account_t   next_seller,
	input  shop_pkg::err_e       calc_err,
	output shop_pkg::account_t   user,
	output shop_pkg::account_t   seller,
	output shop_pkg::item_id_e   item,
	output shop_pkg::item_num_t  count,
	output shop_pkg::money_t     amount,
	output shop_pkg::user_id_t   seller_id,
	output shop_pkg::user_id_t   user_id,
	output logic                 out_valid,
	output logic                 complete,
	output shop_pkg::err_e       err_msg,
	output logic [31:0]          out_info
);
	import shop_pkg::*;

	logic        in_calc;
	err_e        err_hold;
	logic [31:0] info_hold;

	assign in_calc = (state == s_buy_calc) || (state == s_dep_calc);

	// first id of a transaction is the user, a later one the seller
	always_ff @(posedge clk) begin
		if (id_valid && state == s_idle)
			user_id <= data_in.id.val;
		if (id_valid && state != s_idle)
			seller_id <= data_in.id.val;
		if (item_valid)
			item <= data_in.item.val;
		if (num_valid)
			count <= data_in.count.val;
		if (amnt_valid)
			amount <= data_in.money;
	end

	always_ff @(posedge clk) begin
		if (state == s_user_wait && bus.resp_valid)
			user <= bus.resp_data;
		else if (in_calc && calc_err == no_err)
			user <= next_user;

		if (state == s_seller_wait && bus.resp_valid)
			seller <= bus.resp_data;
		else if (in_calc && calc_err == no_err)
			seller <= next_seller;
	end

	always_ff @(posedge clk) begin
		if (in_calc)
			err_hold <= calc_err;
		if (state == s_buy_calc)
			info_hold <= next_user.user;
		else if (state == s_dep_calc)
			info_hold <= {16'd0, next_user.user.money};
	end

	assign bus.req_addr = (state == s_seller_req || state == s_seller_wr) ? seller_id : user_id;
	assign bus.req_data = (state == s_seller_wr) ? seller : user;

	// result fields are zero outside the out_valid cycle
	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			out_valid <= 1'b0;
			complete  <= 1'b0;
			err_msg   <= no_err;
			out_info  <= '0;
		end else if (state == s_out) begin
			out_valid <= 1'b1;
			complete  <= (err_hold == no_err);
			err_msg   <= err_hold;
			out_info  <= (err_hold == no_err) ? info_hold : '0;
		end else begin
			out_valid <= 1'b0;
			complete  <= 1'b0;
			err_msg   <= no_err;
			out_info  <= '0;
		end
	end

endmodule

/* source/trade_calc.sv */
`timescale 1ns/1ps

module trade_calc (
	input  shop_pkg::action_e    action,
	input  shop_pkg::account_t   user,
	input  shop_pkg::account_t   seller,
	input  shop_pkg::item_id_e   item,
	input  shop_pkg::item_num_t  count,
	input  shop_pkg::money_t     amount,
	input  shop_pkg::user_id_t   seller_id,
	output shop_pkg::account_t   next_user,
	output shop_pkg::account_t   next_seller,
	output shop_pkg::err_e       calc_err,
	output logic                 calc_ok
);
	import shop_pkg::*;

	money_t      unit_price;
	money_t      fee;
	exp_t        unit_exp;
	item_num_t   user_cnt;
	item_num_t   seller_cnt;
	logic [6:0]  user_sum;
	logic [16:0] price_total;
	logic [16:0] cost_total;
	logic [16:0] seller_sum;
	logic [16:0] dep_sum;
	logic [12:0] exp_sum;
	level_e      new_level;
	exp_t        new_exp;
	account_t    buy_user;
	account_t    buy_seller;
	account_t    dep_user;
	err_e        buy_err;

	always_comb begin
		case (item)
			item_small:  begin unit_price = price_small;  unit_exp = exp_small; end
			item_medium: begin unit_price = price_medium; unit_exp = exp_medium; end
			item_large:  begin unit_price = price_large;  unit_exp = exp_large; end
			default:     begin unit_price = '0;           unit_exp = '0; end
		endcase
		case (item)
			item_small:  begin user_cnt = user.shop.small_num;  seller_cnt = seller.shop.small_num; end
			item_medium: begin user_cnt = user.shop.medium_num; seller_cnt = seller.shop.medium_num; end
			item_large:  begin user_cnt = user.shop.large_num;  seller_cnt = seller.shop.large_num; end
			default:     begin user_cnt = '0;                   seller_cnt = '0; end
		endcase
		case (user.shop.level)
			lvl_platinum: fee = fee_platinum;
			lvl_gold:     fee = fee_gold;
			lvl_silver:   fee = fee_silver;
			default:      fee = fee_copper;
		endcase
	end

	assign user_sum    = 7'(user_cnt) + 7'(count);
	assign price_total = unit_price * count;
	assign cost_total  = price_total + fee;
	assign seller_sum  = seller.user.money + price_total;
	assign exp_sum     = 13'(user.shop.exp) + 13'(count) * 13'(unit_exp);
	assign dep_sum     = user.user.money + amount;

	// one level step per buy, exp restarts from zero
	always_comb begin
		new_level = user.shop.level;
		new_exp   = exp_sum[11:0];
		case (user.shop.level)
			lvl_copper:
				if (exp_sum >= 13'(exp_to_silver)) begin
					new_level = lvl_silver;
					new_exp   = '0;
				end
			lvl_silver:
				if (exp_sum >= 13'(exp_to_gold)) begin
					new_level = lvl_gold;
					new_exp   = '0;
				end
			lvl_gold:
				if (exp_sum >= 13'(exp_to_platinum)) begin
					new_level = lvl_platinum;
					new_exp   = '0;
				end
			default:
				new_exp = '0;
		endcase
	end

	always_comb begin
		buy_user   = user;
		buy_seller = seller;
		case (item)
			item_small: begin
				buy_user.shop.small_num   = user.shop.small_num + count;
				buy_seller.shop.small_num = seller.shop.small_num - count;
			end
			item_medium: begin
				buy_user.shop.medium_num   = user.shop.medium_num + count;
				buy_seller.shop.medium_num = seller.shop.medium_num - count;
			end
			item_large: begin
				buy_user.shop.large_num   = user.shop.large_num + count;
				buy_seller.shop.large_num = seller.shop.large_num - count;
			end
			default: ;
		endcase
		buy_user.shop.level                  = new_level;
		buy_user.shop.exp                    = new_exp;
		buy_user.user.money                  = user.user.money - cost_total[15:0];
		buy_user.user.shop_history.item_id   = item;
		buy_user.user.shop_history.item_num  = count;
		buy_user.user.shop_history.seller_id = seller_id;
		// seller never gets the fee
		buy_seller.user.money = (seller_sum > 17'(money_max)) ? money_max : seller_sum[15:0];
	end

	// priority: inventory overflow, seller stock, then money
	always_comb begin
		if (user_sum[6])
			buy_err = inv_full;
		else if (seller_cnt < count)
			buy_err = inv_not_enough;
		else if (cost_total > 17'(user.user.money))
			buy_err = out_of_money;
		else
			buy_err = no_err;
	end

	always_comb begin
		dep_user            = user;
		dep_user.user.money = dep_sum[15:0];
	end

	always_comb begin
		case (action)
			act_buy: begin
				next_user   = buy_user;
				next_seller = buy_seller;
				calc_err    = buy_err;
			end
			act_deposit: begin
				next_user   = dep_user;
				next_seller = seller;
				calc_err    = (dep_sum > 17'(money_max)) ? wallet_full : no_err;
			end
			default: begin
				next_user   = user;
				next_seller = seller;
				calc_err    = no_err;
			end
		endcase
	end

	assign calc_ok = (calc_err == no_err);

endmodule

/* source/online_shop.sv */
`timescale 1ns/1ps

module online_shop (
	input  logic                                 clk,
	input  logic                                 inf,
	input  shop_pkg::data_in_t                   data_in,
	input  logic                                 id_valid,
	input  logic                                 act_valid,
	input  logic                                 item_valid,
	input  logic                                 num_valid,
	input  logic                                 amnt_valid,
	input  logic                                 c_out_valid,
	input  logic [shop_pkg::dram_word_bits-1:0]  c_data_r,
	output logic                                 c_in_valid,
	output logic                                 c_r_wb,
	output shop_pkg::user_id_t                   c_addr,
	output logic [shop_pkg::dram_word_bits-1:0]  c_data_w,
	output logic                                 out_valid,
	output shop_pkg::err_e                       err_msg,
	output logic                                 complete,
	output logic [31:0]                          out_info
);
	import shop_pkg::*;

	state_e    state;
	action_e   cur_action;
	logic      calc_ok;
	err_e      calc_err;
	account_t  user;
	account_t  seller;
	account_t  next_user;
	account_t  next_seller;
	item_id_e  item;
	item_num_t count;
	money_t    amount;
	user_id_t  seller_id;
	user_id_t  user_id;

	account_bus_if acc_bus ();

	shop_fsm u_fsm (
		.clk        (clk),
		.inf        (inf),
		.id_valid   (id_valid),
		.act_valid  (act_valid),
		.amnt_valid (amnt_valid),
		.action     (data_in.action.val),
		.calc_ok    (calc_ok),
		.bus        (acc_bus.core),
		.state      (state),
		.cur_action (cur_action)
	);

	account_store u_store (
		.clk         (clk),
		.inf         (inf),
		.state       (state),
		.data_in     (data_in),
		.id_valid    (id_valid),
		.item_valid  (item_valid),
		.num_valid   (num_valid),
		.amnt_valid  (amnt_valid),
		.bus         (acc_bus.core),
		.next_user   (next_user),
		.next_seller (next_seller),
		.calc_err    (calc_err),
		.user        (user),
		.seller      (seller),
		.item        (item),
		.count       (count),
		.amount      (amount),
		.seller_id   (seller_id),
		.user_id     (user_id),
		.out_valid   (out_valid),
		.complete    (complete),
		.err_msg     (err_msg),
		.out_info    (out_info)
	);

	trade_calc u_calc (
		.action      (cur_action),
		.user        (user),
		.seller      (seller),
		.item        (item),
		.count       (count),
		.amount      (amount),
		.seller_id   (seller_id),
		.next_user   (next_user),
		.next_seller (next_seller),
		.calc_err    (calc_err),
		.calc_ok     (calc_ok)
	);

	dram_port u_port (
		.clk         (clk),
		.inf         (inf),
		.bus         (acc_bus.port),
		.c_out_valid (c_out_valid),
		.c_data_r    (c_data_r),
		.c_in_valid  (c_in_valid),
		.c_r_wb      (c_r_wb),
		.c_addr      (c_addr),
		.c_data_w    (c_data_w)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic inf
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		inf = 1'b0;
		repeat (8) @(posedge clk);
		inf <= 1'b1;
	end

endmodule

/* tb/shop_checker.sv */
`timescale 1ns/1ps

module shop_checker (
	input logic             clk,
	input logic             inf,
	input logic             out_valid,
	input logic             complete,
	input shop_pkg::err_e   err_msg,
	input logic             c_in_valid,
	input logic             c_out_valid
);
	import shop_pkg::*;

	int   fail_count = 0;
	logic pending;

	// bridge request in flight
	always_ff @(posedge clk or negedge inf) begin
		if (!inf) begin
			pending <= 1'b0;
		end else if (c_in_valid) begin
			pending <= 1'b1;
		end else if (c_out_valid) begin
			pending <= 1'b0;
		end
	end

	a_out_pulse: assert property (@(posedge clk) disable iff (!inf) out_valid |=> !out_valid)
		else begin
			fail_count++;
			$error("out_valid high for more than one cycle");
		end

	a_one_request: assert property (@(posedge clk) disable iff (!inf) pending |-> !c_in_valid)
		else begin
			fail_count++;
			$error("c_in_valid asserted before c_out_valid answered the last request");
		end

	a_err_complete: assert property (@(posedge clk) disable iff (!inf)
		(err_msg != no_err) |-> !complete)
		else begin
			fail_count++;
			$error("complete high together with an error code");
		end

endmodule

bind online_shop shop_checker u_chk (
	.clk         (clk),
	.inf         (inf),
	.out_valid   (out_valid),
	.complete    (complete),
	.err_msg     (err_msg),
	.c_in_valid  (c_in_valid),
	.c_out_valid (c_out_valid)
);

/* tb/shop_tb.sv */
`timescale 1ns/1ps

module shop_tb;
	import shop_pkg::*;

	logic        clk;
	logic        inf;
	data_in_t    data_in;
	logic        id_valid;
	logic        act_valid;
	logic        item_valid;
	logic        num_valid;
	logic        amnt_valid;
	logic        c_out_valid;
	logic [63:0] c_data_r;
	logic        c_in_valid;
	logic        c_r_wb;
	user_id_t    c_addr;
	logic [63:0] c_data_w;
	logic        out_valid;
	err_e        err_msg;
	logic        complete;
	logic [31:0] out_info;

	logic [63:0] mem [256];
	account_t    exp_mem [256];
	int          write_count = 0;
	logic [15:0] lfsr_state = 16'd97;

	tb_clock_gen u_clk (
		.clk (clk),
		.inf (inf)
	);

	online_shop u_dut (
		.clk         (clk),
		.inf         (inf),
		.data_in     (data_in),
		.id_valid    (id_valid),
		.act_valid   (act_valid),
		.item_valid  (item_valid),
		.num_valid   (num_valid),
		.amnt_valid  (amnt_valid),
		.c_out_valid (c_out_valid),
		.c_data_r    (c_data_r),
		.c_in_valid  (c_in_valid),
		.c_r_wb      (c_r_wb),
		.c_addr      (c_addr),
		.c_data_w    (c_data_w),
		.out_valid   (out_valid),
		.err_msg     (err_msg),
		.complete    (complete),
		.out_info    (out_info)
	);

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// reverses byte order inside each 32-bit half, works both ways
	function automatic logic [63:0] swap_halves(input logic [63:0] v);
		logic [63:0] w;
		int          h;
		int          b;
		for (h = 0; h < 2; h++) begin
			for (b = 0; b < 4; b++) begin
				w[h*32 + b*8 +: 8] = v[h*32 + (3-b)*8 +: 8];
			end
		end
		return w;
	endfunction

	function automatic err_e ref_trade(input action_e act, input user_id_t uid,
		input user_id_t sid, input item_id_e it, input item_num_t cnt, input money_t amt,
		output logic cmp, output logic [31:0] info);
		account_t u;
		account_t s;
		int       have;
		int       stock;
		int       price;
		int       xp;
		int       fee;
		int       cost;
		int       sum;
		err_e     err;
		u = exp_mem[uid];
		s = exp_mem[sid];
		err = no_err;
		cmp = 1'b0;
		info = '0;
		if (act == act_deposit) begin
			sum = int'(u.user.money) + int'(amt);
			if (sum > int'(money_max)) begin
				err = wallet_full;
			end else begin
				u.user.money = money_t'(sum);
				exp_mem[uid] = u;
				info = {16'd0, u.user.money};
			end
			cmp = (err == no_err);
			return err;
		end
		have = 0;
		stock = 0;
		price = 0;
		xp = 0;
		case (it)
			item_small: begin
				have = int'(u.shop.small_num);
				stock = int'(s.shop.small_num);
				price = int'(price_small);
				xp = int'(exp_small);
			end
			item_medium: begin
				have = int'(u.shop.medium_num);
				stock = int'(s.shop.medium_num);
				price = int'(price_medium);
				xp = int'(exp_medium);
			end
			item_large: begin
				have = int'(u.shop.large_num);
				stock = int'(s.shop.large_num);
				price = int'(price_large);
				xp = int'(exp_large);
			end
			default: ;
		endcase
		case (u.shop.level)
			lvl_platinum: fee = int'(fee_platinum);
			lvl_gold:     fee = int'(fee_gold);
			lvl_silver:   fee = int'(fee_silver);
			default:      fee = int'(fee_copper);
		endcase
		cost = price * int'(cnt) + fee;
		if (have + int'(cnt) > 63)
			err = inv_full;
		else if (stock < int'(cnt))
			err = inv_not_enough;
		else if (cost > int'(u.user.money))
			err = out_of_money;
		cmp = (err == no_err);
		if (!cmp)
			return err;
		case (it)
			item_small: begin
				u.shop.small_num = item_num_t'(have + int'(cnt));
				s.shop.small_num = item_num_t'(stock - int'(cnt));
			end
			item_medium: begin
				u.shop.medium_num = item_num_t'(have + int'(cnt));
				s.shop.medium_num = item_num_t'(stock - int'(cnt));
			end
			item_large: begin
				u.shop.large_num = item_num_t'(have + int'(cnt));
				s.shop.large_num = item_num_t'(stock - int'(cnt));
			end
			default: ;
		endcase
		// one level step, exp restarts at zero
		sum = int'(u.shop.exp) + int'(cnt) * xp;
		u.shop.exp = exp_t'(sum);
		if (u.shop.level == lvl_copper && sum >= int'(exp_to_silver)) begin
			u.shop.level = lvl_silver;
			u.shop.exp = '0;
		end else if (u.shop.level == lvl_silver && sum >= int'(exp_to_gold)) begin
			u.shop.level = lvl_gold;
			u.shop.exp = '0;
		end else if (u.shop.level == lvl_gold && sum >= int'(exp_to_platinum)) begin
			u.shop.level = lvl_platinum;
			u.shop.exp = '0;
		end else if (u.shop.level == lvl_platinum) begin
			u.shop.exp = '0;
		end
		u.user.money = money_t'(int'(u.user.money) - cost);
		u.user.shop_history.item_id = it;
		u.user.shop_history.item_num = cnt;
		u.user.shop_history.seller_id = sid;
		sum = int'(s.user.money) + price * int'(cnt);
		s.user.money = (sum > int'(money_max)) ? money_max : money_t'(sum);
		exp_mem[sid] = s;
		exp_mem[uid] = u;
		info = u.user;
		return err;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_err(input err_e got, input err_e exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name()));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_info(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_account(input account_t got, input account_t exp, input string what);
		if (got !== exp)
			abort_run($sformatf("[FAIL] t=%0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp)
			abort_run($sformatf("[FAIL] t=%0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	// sel order: id, act, item, num, amnt
	task automatic pulse(input logic [15:0] value, input logic [4:0] sel);
		@(posedge clk);
		data_in <= value;
		{id_valid, act_valid, item_valid, num_valid, amnt_valid} <= sel;
		@(posedge clk);
		{id_valid, act_valid, item_valid, num_valid, amnt_valid} <= 5'b0;
		data_in <= '0;
	endtask

	task automatic load_account(input user_id_t addr, input level_e lvl, input exp_t xp,
		input item_num_t lg, input item_num_t md, input item_num_t sm, input money_t money);
		account_t a;
		a = '0;
		a.shop.level = lvl;
		a.shop.exp = xp;
		a.shop.large_num = lg;
		a.shop.medium_num = md;
		a.shop.small_num = sm;
		a.user.money = money;
		exp_mem[addr] = a;
		mem[addr] = swap_halves(a);
	endtask

	task automatic run_trade(input action_e act, input user_id_t uid, input user_id_t sid,
		input item_id_e it, input item_num_t cnt, input money_t amt);
		err_e        exp_err;
		logic        exp_cmp;
		logic [31:0] exp_info;
		int          writes_before;
		int          waited;
		writes_before = write_count;
		exp_err = ref_trade(act, uid, sid, it, cnt, amt, exp_cmp, exp_info);
		pulse(16'(uid), 5'b10000);
		pulse(16'(act), 5'b01000);
		if (act == act_buy) begin
			pulse(16'(it), 5'b00100);
			pulse(16'(cnt), 5'b00010);
			pulse(16'(sid), 5'b10000);
		end else begin
			pulse(amt, 5'b00001);
		end
		waited = 0;
		@(posedge clk);
		while (out_valid !== 1'b1) begin
			waited++;
			if (waited > 200)
				abort_run("timeout: no out_valid within 200 cycles of the last input");
			@(posedge clk);
		end
		check_err(err_msg, exp_err, "err_msg");
		check_flag(complete, exp_cmp, "complete");
		check_info(out_info, exp_info, "out_info");
		check_count(write_count - writes_before, !exp_cmp ? 0 : (act == act_buy ? 2 : 1),
			"memory writes");
		check_account(swap_halves(mem[uid]), exp_mem[uid], "user account");
		if (act == act_buy)
			check_account(swap_halves(mem[sid]), exp_mem[sid], "seller account");
	endtask

	// bridge model, one request at a time, latency 1 to 8 cycles
	initial begin : bridge_model
		int          lat;
		logic [63:0] rdata;
		c_out_valid = 1'b0;
		c_data_r = '0;
		forever begin
			@(posedge clk);
			if (c_in_valid === 1'b1) begin
				lat = int'(rand_bits(3)) + 1;
				rdata = '0;
				if (c_r_wb) begin
					rdata = mem[c_addr];
				end else begin
					mem[c_addr] = c_data_w;
					write_count++;
				end
				repeat (lat - 1) @(posedge clk);
				c_out_valid <= 1'b1;
				c_data_r <= rdata;
				@(posedge clk);
				c_out_valid <= 1'b0;
				c_data_r <= '0;
			end
		end
	end

	initial begin
		repeat (8 + 30 * 200) @(posedge clk);
		abort_run("watchdog expired before all transactions finished");
	end

	always @(posedge clk) begin
		if (u_dut.u_chk.fail_count != 0)
			abort_run("a protocol assertion in shop_checker failed");
	end

	initial begin : stimulus
		account_t  acct;
		action_e   act;
		user_id_t  uid;
		user_id_t  sid;
		item_id_e  it;
		item_num_t cnt;
		money_t    amt;
		int        a;
		data_in = '0;
		id_valid = 1'b0;
		act_valid = 1'b0;
		item_valid = 1'b0;
		num_valid = 1'b0;
		amnt_valid = 1'b0;
		for (a = 0; a < 256; a++) begin
			acct = {rand_bits(32), rand_bits(32)};
			acct.user.shop_history.seller_id = user_id_t'(a);
			exp_mem[a] = acct;
			mem[a] = swap_halves(acct);
		end

		wait (inf === 1'b1);
		@(posedge clk);
		check_flag(out_valid, 1'b0, "out_valid after reset");
		check_flag(complete, 1'b0, "complete after reset");
		check_flag(c_in_valid, 1'b0, "c_in_valid after reset");
		check_flag(c_r_wb, 1'b0, "c_r_wb after reset");
		check_err(err_msg, no_err, "err_msg after reset");

		load_account(8'h10, lvl_copper, 12'd0, 6'd5, 6'd5, 6'd5, 16'd1000);
		run_trade(act_deposit, 8'h10, 8'h00, item_none, 6'd0, 16'd2345);
		load_account(8'h11, lvl_silver, 12'd0, 6'd0, 6'd0, 6'd0, 16'd65000);
		run_trade(act_deposit, 8'h11, 8'h00, item_none, 6'd0, 16'd600);

		// copper to silver, seller money saturates
		load_account(8'h20, lvl_copper, 12'd950, 6'd0, 6'd0, 6'd0, 16'd20000);
		load_account(8'h21, lvl_gold, 12'd0, 6'd0, 6'd0, 6'd40, 16'd65000);
		run_trade(act_buy, 8'h20, 8'h21, item_small, 6'd10, 16'd0);

		// every error source active, then one less each time
		load_account(8'h30, lvl_gold, 12'd0, 6'd60, 6'd0, 6'd0, 16'd50);
		load_account(8'h31, lvl_gold, 12'd0, 6'd2, 6'd0, 6'd0, 16'd100);
		run_trade(act_buy, 8'h30, 8'h31, item_large, 6'd5, 16'd0);
		run_trade(act_buy, 8'h30, 8'h31, item_large, 6'd3, 16'd0);
		run_trade(act_buy, 8'h30, 8'h31, item_large, 6'd2, 16'd0);

		repeat (20) begin
			uid = user_id_t'(rand_bits(8));
			sid = user_id_t'(rand_bits(8));
			if (sid == uid)
				sid = uid + 8'd1;
			it = item_id_e'(rand_bits(2));
			if (it == item_none)
				it = item_large;
			cnt = item_num_t'(rand_bits(4));
			amt = money_t'(rand_bits(16));
			act = (rand_bits(2) == 0) ? act_deposit : act_buy;
			run_trade(act, uid, sid, it, cnt, amt);
		end

		repeat (4) @(posedge clk);
		if (u_dut.u_chk.fail_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* vlog.f */
source/shop_pkg.sv
source/account_bus_if.sv
source/dram_port.sv
source/shop_fsm.sv
source/account_store.sv
source/trade_calc.sv
source/online_shop.sv
tb/tb_clock_gen.sv
tb/shop_checker.sv
tb/shop_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module shop_tb -f vlog.f -Mdir obj_dir &&
./obj_dir/Vshop_tb +verilator+error+limit+100 | tee /dev/stderr | grep -qx "test passed" &&
echo "simulation ok" ||
{ echo "simulation reported failure"; exit 1; }
